//--- eeprom_cases.txt
# op ctrl addr data rnd, op: w write, r read, x write stopped after address, b foreign control
# ctrl, addr and data in hex, rnd 1 replaces data with a random byte
w a0 0010 5a 0
r a2 0010 00 0
w a2 0020 11 0
w a6 0021 22 0
w aa 0022 33 0
w ae 0023 44 0
r a0 0023 00 0
r a4 0022 00 0
r a8 0021 00 0
r ac 0020 00 0
b 50 0010 ee 0
b b0 0020 ee 0
r a0 0010 00 0
x a0 0020 99 0
r a0 0020 00 0
w a0 e123 3c 0
r ae 0123 00 0
w a4 1f00 ff 1
w a8 0abc ff 1
w ac 1555 ff 1
r a6 1f00 00 0
r aa 0abc 00 0
r a2 1555 00 0
r a0 0777 00 0

//--- list.f
eeprom_pkg.sv
bus_byte_if.sv
i2c_line_sync.sv
i2c_byte_shifter.sv
eeprom_ctrl_fsm.sv
eeprom_mem_array.sv
eeprom_top.sv
tb_eeprom.sv

//--- tb_eeprom.sv
`timescale 1ns/1ps

module tb_eeprom;

    localparam int ADDR_W     = 13;
    localparam int DEPTH      = 1 << ADDR_W;
    localparam int MAX_CASES  = 64;
    localparam int BIT_CYCLES = 16;  // scl cycles per bus bit

    logic scl;
    logic rst_n;
    logic bus_clk;
    logic sda_pull;                  // master pulls sda low
    wire  sda;

    pullup (sda);
    assign sda = sda_pull ? 1'b0 : 1'bz;

    eeprom_top #(.ADDR_W(ADDR_W)) dut0 (
        .scl     (scl),
        .rst_n   (rst_n),
        .bus_clk (bus_clk),
        .sda     (sda)
    );

    logic [7:0]  case_op   [0:MAX_CASES-1];
    logic [7:0]  case_ctrl [0:MAX_CASES-1];
    logic [15:0] case_addr [0:MAX_CASES-1];
    logic [7:0]  case_data [0:MAX_CASES-1];
    int          case_rnd  [0:MAX_CASES-1];
    logic [7:0]  sb        [0:DEPTH-1];  // expected array contents

    int   n_cases;
    int   seed;
    int   cycle_cnt;
    int   cycle_limit;
    int   pass_cnt;
    int   fail_cnt;
    logic test_ok;

    always #20 scl = ~scl;

    // ------------------------------
    // watchdog
    // ------------------------------
    always @(posedge scl)
    begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_limit != 0 && cycle_cnt >= cycle_limit)
        begin
            $display("timeout: bus transactions still running after %0d cycles", cycle_cnt);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge scl);
    endtask

    // one bit in four quarters, sda moves only with bus_clk low
    task automatic bus_bit(input logic pull_low, output logic seen);
        idle_cycles(BIT_CYCLES / 4);
        sda_pull = pull_low;
        idle_cycles(BIT_CYCLES / 4);
        bus_clk = 1'b1;
        idle_cycles(BIT_CYCLES / 4);
        seen = sda;                  // middle of the high phase
        idle_cycles(BIT_CYCLES / 4);
        bus_clk = 1'b0;
    endtask

    task automatic start_cond;
        idle_cycles(BIT_CYCLES / 4);
        sda_pull = 1'b0;
        idle_cycles(BIT_CYCLES / 4);
        bus_clk = 1'b1;
        idle_cycles(BIT_CYCLES / 4);
        sda_pull = 1'b1;             // sda falls, bus_clk high
        idle_cycles(BIT_CYCLES / 4);
        bus_clk = 1'b0;
    endtask

    task automatic stop_cond;
        idle_cycles(BIT_CYCLES / 4);
        sda_pull = 1'b1;
        idle_cycles(BIT_CYCLES / 4);
        bus_clk = 1'b1;
        idle_cycles(BIT_CYCLES / 4);
        sda_pull = 1'b0;             // sda rises, bus_clk high
        idle_cycles(BIT_CYCLES / 4);
    endtask

    // msb first, then the ack slot with sda released
    task automatic send_byte(input logic [7:0] b, input logic want_ack, input string what);
        logic seen;
        int   i;
        for (i = 7; i >= 0; i--)
            bus_bit(!b[i], seen);
        bus_bit(1'b0, seen);
        if (want_ack && seen)
        begin
            $display("at %0t the device did not ack the %s (%02h)", $time, what, b);
            test_ok = 1'b0;
        end
        if (!want_ack && !seen)
        begin
            $display("at %0t the device acked the %s (%02h) but should not have", $time, what, b);
            test_ok = 1'b0;
        end
    endtask

    task automatic recv_byte(output logic [7:0] b, output logic nack_level);
        logic seen;
        int   i;
        for (i = 7; i >= 0; i--)
        begin
            bus_bit(1'b0, seen);
            b[i] = seen;
        end
        bus_bit(1'b0, nack_level);   // master nack
    endtask

    // ------------------------------
    // case file
    // ------------------------------
    task automatic load_cases;
        int          fd;
        int          code;
        int          ch;
        int          r;
        logic [7:0]  op;
        logic [7:0]  c;
        logic [15:0] a;
        logic [7:0]  d;
        n_cases = 0;
        fd = $fopen("eeprom_cases.txt", "r");
        if (fd == 0)
        begin
            $display("could not open eeprom_cases.txt");
            fail_cnt++;
        end
        else
        begin
            code = $fscanf(fd, " %c", op);
            while (code == 1 && n_cases < MAX_CASES)
            begin
                if (op == "#")
                begin
                    ch = $fgetc(fd);
                    while (ch >= 0 && ch != 10)
                        ch = $fgetc(fd);  // skip to end of line
                end
                else
                begin
                    code = $fscanf(fd, " %h %h %h %d", c, a, d, r);
                    if (code == 4)
                    begin
                        case_op[n_cases]   = op;
                        case_ctrl[n_cases] = c;
                        case_addr[n_cases] = a;
                        case_data[n_cases] = d;
                        case_rnd[n_cases]  = r;
                        n_cases++;
                    end
                    else
                    begin
                        $display("malformed line after case %0d in eeprom_cases.txt", n_cases);
                        fail_cnt++;
                    end
                end
                code = $fscanf(fd, " %c", op);
            end
            $fclose(fd);
        end
    endtask

    // ------------------------------
    // one transaction per case
    // ------------------------------
    task automatic run_case(input int n);
        logic [7:0]        op;
        logic [7:0]        ctrl;
        logic [15:0]       addr;
        logic [7:0]        data;
        logic [7:0]        got;
        logic [ADDR_W-1:0] idx;
        logic              nack_level;
        int                rnd_word;
        op      = case_op[n];
        ctrl    = case_ctrl[n];
        addr    = case_addr[n];
        data    = case_data[n];
        idx     = addr[ADDR_W-1:0];  // bits above ADDR_W dropped
        test_ok = 1'b1;
        if (case_rnd[n] != 0)
        begin
            rnd_word = $random(seed);
            data     = rnd_word[7:0];
        end

        start_cond;
        if (op == "b")
        begin
            send_byte(ctrl, 1'b0, "foreign control byte");
            send_byte(addr[15:8], 1'b0, "address high byte");
            send_byte(addr[7:0], 1'b0, "address low byte");
            send_byte(data, 1'b0, "data byte");
            stop_cond;
        end
        else
        begin
            send_byte(ctrl & 8'hfe, 1'b1, "control byte");
            send_byte(addr[15:8], 1'b1, "address high byte");
            send_byte(addr[7:0], 1'b1, "address low byte");
            if (op == "w")
            begin
                send_byte(data, 1'b1, "data byte");
                sb[idx] = data;
            end
            else if (op == "r")
            begin
                start_cond;          // repeated start
                send_byte(ctrl | 8'h01, 1'b1, "read control byte");
                recv_byte(got, nack_level);
                if (got !== sb[idx])
                begin
                    $display("mismatch at %0t: rdata[%04h] expected %02h actual %02h",
                             $time, idx, sb[idx], got);
                    test_ok = 1'b0;
                end
                if (nack_level !== 1'b1)
                begin
                    $display("mismatch at %0t: sda in nack slot expected 1 actual %b",
                             $time, nack_level);
                    test_ok = 1'b0;
                end
            end
            stop_cond;               // an x case stops before the data byte
        end
        idle_cycles(BIT_CYCLES * 2);  // room for the commit
        if (sda !== 1'b1)
        begin
            $display("mismatch at %0t: sda after stop expected 1 actual %b", $time, sda);
            test_ok = 1'b0;
        end

        if (test_ok)
        begin
            pass_cnt++;
            $display("test %0d %c ctrl %02h addr %04h data %02h: ok", n, op, ctrl, addr, data);
        end
        else
        begin
            fail_cnt++;
            $display("test %0d %c ctrl %02h addr %04h data %02h: failed", n, op, ctrl, addr, data);
        end
    endtask

    initial
    begin
        scl         = 1'b0;
        rst_n       = 1'b0;
        bus_clk     = 1'b1;          // idle bus
        sda_pull    = 1'b0;
        seed        = 32'h3a51d6b8;
        cycle_cnt   = 0;
        cycle_limit = 0;
        pass_cnt    = 0;
        fail_cnt    = 0;
        test_ok     = 1'b1;
        for (int i = 0; i < DEPTH; i++)
            sb[i] = 8'h00;           // blank part

        load_cases;
        cycle_limit = n_cases * 60 * BIT_CYCLES * 2;

        idle_cycles(10);
        rst_n = 1'b1;
        idle_cycles(4);

        for (int i = 0; i < n_cases; i++)
            run_case(i);

        $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && n_cases > 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

//--- eeprom_top.sv
`timescale 1ns/1ps

module eeprom_top import eeprom_pkg::*;
#(
    parameter int ADDR_W = ADDR_W_DEFAULT
)
(
    input  logic scl,
    input  logic rst_n,
    input  logic bus_clk,
    inout  wire  sda
);

    logic              clk_rise;
    logic              clk_fall;
    logic              start;
    logic              stop;
    logic              sda_in;
    logic              sda_low;
    logic              mem_we;
    logic [ADDR_W-1:0] mem_addr;
    byte_t             mem_wdata;
    byte_t             mem_rdata;

    bus_byte_if bus0 ();

    // ------------------------------
    // bus front end
    // ------------------------------
    i2c_line_sync u_line_sync (
        .scl      (scl),
        .rst_n    (rst_n),
        .bus_clk  (bus_clk),
        .sda      (sda),
        .sda_low  (sda_low),
        .clk_rise (clk_rise),
        .clk_fall (clk_fall),
        .start    (start),
        .stop     (stop),
        .sda_in   (sda_in)
    );

    i2c_byte_shifter u_shifter (
        .scl      (scl),
        .rst_n    (rst_n),
        .clk_rise (clk_rise),
        .clk_fall (clk_fall),
        .start_in (start),
        .stop_in  (stop),
        .sda_in   (sda_in),
        .sda_low  (sda_low),
        .bus      (bus0.shifter)
    );

    // ------------------------------
    // protocol and storage
    // ------------------------------
    eeprom_ctrl_fsm #(.ADDR_W(ADDR_W)) u_ctrl (
        .scl       (scl),
        .rst_n     (rst_n),
        .bus       (bus0.ctrl),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

    eeprom_mem_array #(.ADDR_W(ADDR_W)) u_mem (
        .scl   (scl),
        .we    (mem_we),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .rdata (mem_rdata)
    );

endmodule

//--- eeprom_mem_array.sv
`timescale 1ns/1ps

module eeprom_mem_array import eeprom_pkg::*;
#(
    parameter int ADDR_W = ADDR_W_DEFAULT
)
(
    input  logic              scl,
    input  logic              we,
    input  logic [ADDR_W-1:0] addr,
    input  byte_t             wdata,
    output byte_t             rdata
);

    localparam int DEPTH = 1 << ADDR_W;

    byte_t mem [0:DEPTH-1];

    // blank part at power up
    initial
    begin
        for (int i = 0; i < DEPTH; i++)
            mem[i] = '0;
    end

    always @(posedge scl)
    begin
        if (we)
            mem[addr] <= wdata;
    end

    always_ff @(posedge scl)
    begin
        rdata <= mem[addr];  // registered read
    end

endmodule

//--- eeprom_ctrl_fsm.sv
`timescale 1ns/1ps

module eeprom_ctrl_fsm import eeprom_pkg::*;
#(
    parameter int ADDR_W = ADDR_W_DEFAULT
)
(
    input  logic              scl,
    input  logic              rst_n,
    bus_byte_if.ctrl          bus,
    output logic              mem_we,
    output logic [ADDR_W-1:0] mem_addr,
    output byte_t             mem_wdata,
    input  byte_t             mem_rdata
);

    ctrl_state_t state;
    byte_t       addr_h;
    byte_t       addr_l;
    byte_t       wdata_r;
    logic [1:0]  rd_pipe;     // read request to tx_load
    logic [15:0] addr_full;
    logic        family_ok;
    logic        rw_bit;

    assign family_ok = (bus.rx_byte[7:4] == ctrl_family);  // select bits ignored
    assign rw_bit    = bus.rx_byte[0];
    assign addr_full = {addr_h, addr_l};
    assign mem_addr  = addr_full[ADDR_W-1:0];  // upper address bits dropped
    assign mem_wdata = wdata_r;

    assign bus.tx_byte = mem_rdata;
    assign bus.tx_load = rd_pipe[1];

    // ------------------------------
    // ack decision
    // ------------------------------
    always_comb
    begin
        case (state)
            st_ctrl:    bus.ack_en = family_ok && !rw_bit;
            st_rctrl:   bus.ack_en = family_ok && rw_bit;
            st_addr_h,
            st_addr_l,
            st_wait_rs: bus.ack_en = 1'b1;
            default:    bus.ack_en = 1'b0;  // extra bytes not acked
        endcase
    end

    // ------------------------------
    // transaction sequencing
    // ------------------------------
    always_ff @(posedge scl)
    begin
        if (!rst_n)
        begin
            state   <= st_idle;
            mem_we  <= 1'b0;
            rd_pipe <= '0;
        end
        else
        begin
            mem_we  <= bus.stop && (state == st_wdata);  // complete write only
            rd_pipe <= {rd_pipe[0], 1'b0};

            if (bus.stop)
                state <= st_idle;
            else if (bus.start)
            begin
                if (state == st_wait_rs)
                    state <= st_rctrl;              // random read
                else if (state != st_ignore)
                    state <= st_ctrl;
            end
            else if (bus.rx_done)
            begin
                case (state)
                    st_ctrl:    state <= bus.ack_en ? st_addr_h : st_ignore;
                    st_addr_h:  state <= st_addr_l;
                    st_addr_l:  state <= st_wait_rs;
                    st_wait_rs: state <= st_wdata;
                    st_rctrl:
                    begin
                        if (bus.ack_en)
                        begin
                            state      <= st_rdata;
                            rd_pipe[0] <= 1'b1;  // rdata valid two cycles on
                        end
                        else
                            state <= st_ignore;
                    end
                    st_wdata:   state <= st_ignore;  // no page writes
                    default:    state <= state;
                endcase
            end
            else if (bus.tx_done && (state == st_rdata))
                state <= bus.master_ack ? st_idle : st_ignore;  // no sequential read
        end
    end

    // address and data capture
    always_ff @(posedge scl)
    begin
        if (bus.rx_done)
        begin
            case (state)
                st_addr_h:  addr_h  <= bus.rx_byte;
                st_addr_l:  addr_l  <= bus.rx_byte;
                st_wait_rs: wdata_r <= bus.rx_byte;
                default:    wdata_r <= wdata_r;
            endcase
        end
    end

    // ------------------------------
    // checks
    // ------------------------------
    // commit only right after a stop, with the shifter quiet
    a_we_at_stop: assert property (@(posedge scl) disable iff (!rst_n)
        mem_we |-> ($past(bus.stop) && !bus.rx_done && !bus.tx_done));

endmodule

//--- i2c_byte_shifter.sv
`timescale 1ns/1ps

module i2c_byte_shifter import eeprom_pkg::*;
(
    input  logic        scl,
    input  logic        rst_n,
    input  logic        clk_rise,
    input  logic        clk_fall,
    input  logic        start_in,
    input  logic        stop_in,
    input  logic        sda_in,
    output logic        sda_low,
    bus_byte_if.shifter bus
);

    logic [3:0] bit_cnt;      // rising edges seen in this frame, 8 = ack slot
    byte_t      rx_shift;
    byte_t      tx_reg;
    logic       tx_mode;
    logic       tx_first;     // loaded, still inside the last rx ack slot
    logic       ack_pending;  // drive ack on the next falling edge

    assign bus.start   = start_in;
    assign bus.stop    = stop_in;
    assign bus.rx_byte = rx_shift;

    // ------------------------------
    // frame control
    // ------------------------------
    always_ff @(posedge scl)
    begin
        if (!rst_n)
        begin
            bit_cnt        <= '0;
            tx_mode        <= 1'b0;
            tx_first       <= 1'b0;
            ack_pending    <= 1'b0;
            sda_low        <= 1'b0;
            bus.rx_done    <= 1'b0;
            bus.tx_done    <= 1'b0;
            bus.master_ack <= 1'b1;
        end
        else if (start_in || stop_in)
        begin
            bit_cnt     <= '0;          // new frame
            tx_mode     <= 1'b0;
            tx_first    <= 1'b0;
            ack_pending <= 1'b0;
            sda_low     <= 1'b0;        // let go of the line
            bus.rx_done <= 1'b0;
            bus.tx_done <= 1'b0;
        end
        else
        begin
            bus.rx_done <= clk_rise && !tx_mode && (bit_cnt == 4'd7);
            bus.tx_done <= clk_rise && tx_mode && !tx_first && (bit_cnt == 4'd8);

            if (bus.rx_done)
                ack_pending <= bus.ack_en;

            if (bus.tx_done)
                tx_mode <= 1'b0;

            if (clk_rise)
            begin
                if (bit_cnt == 4'd8)
                begin
                    bit_cnt  <= '0;
                    tx_first <= 1'b0;
                    if (tx_mode && !tx_first)
                        bus.master_ack <= sda_in;  // 0 = master wants more
                end
                else
                begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end

            if (bus.tx_load)
            begin
                tx_mode  <= 1'b1;
                tx_first <= 1'b1;
            end

            // sda only changes while bus_clk is low
            if (clk_fall)
            begin
                if (ack_pending)
                begin
                    sda_low     <= 1'b1;
                    ack_pending <= 1'b0;
                end
                else if (tx_mode && !tx_first && (bit_cnt < 4'd8))
                    sda_low <= ~tx_reg[3'd7 - bit_cnt[2:0]];  // msb first
                else
                    sda_low <= 1'b0;
            end
        end
    end

    // payload, no reset needed
    always_ff @(posedge scl)
    begin
        if (clk_rise && !tx_mode && (bit_cnt < 4'd8))
            rx_shift <= {rx_shift[6:0], sda_in};
        if (bus.tx_load)
            tx_reg <= bus.tx_byte;
    end

    // ------------------------------
    // checks
    // ------------------------------
    a_quiet_during_rx: assert property (@(posedge scl) disable iff (!rst_n)
        (!tx_mode && (bit_cnt inside {[4'd1:4'd7]})) |-> !sda_low);

    a_load_in_ack_slot: assert property (@(posedge scl) disable iff (!rst_n)
        bus.tx_load |-> (!tx_mode && (bit_cnt == 4'd8)));

endmodule

//--- i2c_line_sync.sv
`timescale 1ns/1ps

module i2c_line_sync import eeprom_pkg::*;
(
    input  logic scl,
    input  logic rst_n,
    input  logic bus_clk,
    inout  wire  sda,
    input  logic sda_low,
    output logic clk_rise,
    output logic clk_fall,
    output logic start,
    output logic stop,
    output logic sda_in
);

    logic [SYNC_STAGES-1:0] clk_sync;
    logic [SYNC_STAGES-1:0] sda_sync;
    logic                   clk_prev;
    logic                   sda_prev;
    logic                   clk_now;
    logic                   sda_now;
    logic                   sda_oe;

    // ------------------------------
    // open-drain pin
    // ------------------------------
    assign sda = sda_oe ? 1'b0 : 1'bz;  // pulled up on the board

    assign clk_now = clk_sync[SYNC_STAGES-1];
    assign sda_now = sda_sync[SYNC_STAGES-1];
    assign sda_in  = sda_prev;           // lines up with clk_rise

    always_ff @(posedge scl)
    begin
        if (!rst_n)
        begin
            clk_sync <= '1;              // idle bus is high
            sda_sync <= '1;
            clk_prev <= 1'b1;
            sda_prev <= 1'b1;
            clk_rise <= 1'b0;
            clk_fall <= 1'b0;
            start    <= 1'b0;
            stop     <= 1'b0;
            sda_oe   <= 1'b0;
        end
        else
        begin
            clk_sync <= {clk_sync[SYNC_STAGES-2:0], bus_clk};
            sda_sync <= {sda_sync[SYNC_STAGES-2:0], sda};
            clk_prev <= clk_now;
            sda_prev <= sda_now;
            clk_rise <= clk_now && !clk_prev;
            clk_fall <= !clk_now && clk_prev;
            // sda may only move with bus_clk high at start or stop
            start    <= clk_now && clk_prev && sda_prev && !sda_now;
            stop     <= clk_now && clk_prev && !sda_prev && sda_now;
            sda_oe   <= sda_low;
        end
    end

    // ------------------------------
    // checks
    // ------------------------------
    // a start or stop is always the master's, never our own pull
    a_no_drive_at_start_stop: assert property (@(posedge scl) disable iff (!rst_n)
        (start || stop) |-> !sda_oe);

endmodule

//--- bus_byte_if.sv
`timescale 1ns/1ps

interface bus_byte_if import eeprom_pkg::*; ();

    // shifter side
    logic  start;       // start or repeated start pulse
    logic  stop;        // stop pulse
    byte_t rx_byte;     // last byte shifted in
    logic  rx_done;     // eighth bit sampled
    logic  tx_done;     // master ack slot finished
    logic  master_ack;  // sda in that slot, 0 = ack

    // controller side
    logic  ack_en;      // ack the byte flagged by rx_done
    byte_t tx_byte;
    logic  tx_load;     // load tx_byte for sending

    modport shifter (
        output start,
        output stop,
        output rx_byte,
        output rx_done,
        output tx_done,
        output master_ack,
        input  ack_en,
        input  tx_byte,
        input  tx_load
    );

    modport ctrl (
        input  start,
        input  stop,
        input  rx_byte,
        input  rx_done,
        input  tx_done,
        input  master_ack,
        output ack_en,
        output tx_byte,
        output tx_load
    );

endinterface

//--- eeprom_pkg.sv
package eeprom_pkg;

    // ------------------------------
    // bus framing constants
    // ------------------------------
    localparam logic [3:0] ctrl_family = 4'b1010;  // device type nibble

    localparam int ADDR_W_DEFAULT = 13;  // 64 kbit part
    localparam int SYNC_STAGES    = 2;   // flops per input line

    typedef logic [7:0] byte_t;

    // ------------------------------
    // controller states
    // ------------------------------
    typedef enum logic [3:0] {
        st_idle    = 4'd0,  // waiting for start
        st_ctrl    = 4'd1,  // first control byte
        st_addr_h  = 4'd2,
        st_addr_l  = 4'd3,
        st_wait_rs = 4'd4,  // data byte or repeated start
        st_wdata   = 4'd5,  // data held, commit on stop
        st_rctrl   = 4'd6,  // control byte after repeated start
        st_rdata   = 4'd7,  // byte going out
        st_ignore  = 4'd8   // not addressed, wait for stop
    } ctrl_state_t;

endpackage
